// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_net_tx
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := net_tx_defines.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== eth_crc32.sv ====
// byte-wide Ethernet fcs accumulator, reflected poly 0x04C11DB7
// register starts at all ones, crc output is already complemented
// send crc least significant byte first, clear wins over update
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
  input  wire                tx_clock,
  input  wire                rst_n,
  input  wire                clear,
  input  wire                update,
  input  wire net_tx_pkg::byte_t data,
  output net_tx_pkg::crc_t   crc
);

  import net_tx_pkg::*;

  // bit-reversed form of 0x04C11DB7
  localparam crc_t POLY_REFL = 32'hEDB88320;

  crc_t crc_reg;

  // one byte through the lsb-first shift register
  function automatic crc_t crc_step(input crc_t c, input byte_t d);
    crc_t acc;
    acc = c ^ {24'h000000, d};
    for (int b = 0; b < 8; b++) begin
      acc = acc[0] ? ((acc >> 1) ^ POLY_REFL) : (acc >> 1);
    end
    return acc;
  endfunction

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      crc_reg <= '1;
    end else if (clear) begin
      crc_reg <= '1;
    end else if (update) begin
      crc_reg <= crc_step(crc_reg, data);
    end
  end

  assign crc = ~crc_reg;

endmodule

`default_nettype wire

// ==== mac_framer.sv ====
// fixed-priority framer: arp before icmp before udp, one whole frame each
// dest_mac of the granted source must stay stable until its fcs is out
// out_valid and out_byte are combinational, one byte per held credit
// sink must never hand out more than OUT_CREDIT_MAX credits
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module mac_framer (
  input  wire                        tx_clock,
  input  wire                        rst_n,
  // queue side
  input  wire [`NUM_SOURCES-1:0]     frame_ready,
  input  wire net_tx_pkg::src_byte_t head [`NUM_SOURCES],
  input  wire net_tx_pkg::mac_addr_t dest_mac [`NUM_SOURCES],
  input  wire net_tx_pkg::mac_addr_t local_mac,
  output logic [`NUM_SOURCES-1:0]    pop,
  // sink side
  input  wire                        out_credit,
  output logic                       out_valid,
  output net_tx_pkg::tx_byte_t       out_byte
);

  import net_tx_pkg::*;

  localparam int CW = $clog2(`OUT_CREDIT_MAX + 1);
  // field index, wide enough for a full payload count
  localparam int IW = $clog2(`MAX_PAYLOAD + 1);

  framer_state_t state;
  src_sel_t      grant;
  src_sel_t      pick;
  logic [IW-1:0] idx;
  logic [CW-1:0] credit_cnt;
  logic          send;
  logic          crc_update;
  byte_t         cur_data;
  ethertype_t    etype;
  crc_t          fcs;

  // msb-first byte of a mac address
  function automatic byte_t mac_byte(input mac_addr_t mac, input logic [IW-1:0] i);
    mac_addr_t sh;
    sh = mac << (8 * i);
    return sh[47:40];
  endfunction

  // ------------------------------
  // arbitration
  // ------------------------------
  always_comb begin
    if (frame_ready[SRC_ARP]) begin
      pick = SRC_ARP;
    end else if (frame_ready[SRC_ICMP]) begin
      pick = SRC_ICMP;
    end else begin
      pick = SRC_UDP;
    end
  end

  // a byte leaves whenever a frame is open and a credit is held
  assign send  = (state != FR_IDLE) && (credit_cnt != '0);
  assign etype = (grant == SRC_ARP) ? `ETHERTYPE_ARP : `ETHERTYPE_IPV4;

  // ------------------------------
  // byte mux
  // ------------------------------
  always_comb begin
    case (state)
      FR_PREAMBLE: cur_data = (idx == IW'(7)) ? 8'hD5 : 8'h55;
      FR_DEST:     cur_data = mac_byte(dest_mac[grant], idx);
      FR_SRC:      cur_data = mac_byte(local_mac, idx);
      FR_TYPE:     cur_data = (idx == '0) ? etype[15:8] : etype[7:0];
      FR_PAYLOAD:  cur_data = head[grant].data;
      FR_FCS: begin
        // lsb first
        case (idx[1:0])
          2'd0:    cur_data = fcs[7:0];
          2'd1:    cur_data = fcs[15:8];
          2'd2:    cur_data = fcs[23:16];
          default: cur_data = fcs[31:24];
        endcase
      end
      // pad and idle
      default:     cur_data = 8'h00;
    endcase
  end

  assign out_valid     = send;
  assign out_byte.data = cur_data;
  assign out_byte.last = (state == FR_FCS) && (idx == IW'(3));

  // payload bytes only come from the granted queue
  always_comb begin
    pop = '0;
    if (send && (state == FR_PAYLOAD)) begin
      pop[grant] = 1'b1;
    end
  end

  // fcs covers dest through pad, not preamble
  assign crc_update = send && (state != FR_PREAMBLE) && (state != FR_FCS);

  eth_crc32 i_crc (
    .tx_clock (tx_clock),
    .rst_n    (rst_n),
    .clear    (state == FR_IDLE),
    .update   (crc_update),
    .data     (cur_data),
    .crc      (fcs)
  );

  // ------------------------------
  // credits
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({out_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // ------------------------------
  // field sequencer
  // ------------------------------
  // without a send everything holds, so back-pressure loses nothing
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= FR_IDLE;
      grant <= SRC_ARP;
      idx   <= '0;
    end else if (state == FR_IDLE) begin
      // grant held until the fcs is out
      if ((credit_cnt != '0) && (|frame_ready)) begin
        grant <= pick;
        state <= FR_PREAMBLE;
        idx   <= '0;
      end
    end else if (send) begin
      idx <= idx + 1'b1;
      case (state)
        FR_PREAMBLE: begin
          if (idx == IW'(7)) begin
            state <= FR_DEST;
            idx   <= '0;
          end
        end
        FR_DEST: begin
          if (idx == IW'(5)) begin
            state <= FR_SRC;
            idx   <= '0;
          end
        end
        FR_SRC: begin
          if (idx == IW'(5)) begin
            state <= FR_TYPE;
            idx   <= '0;
          end
        end
        FR_TYPE: begin
          if (idx == IW'(1)) begin
            state <= FR_PAYLOAD;
            idx   <= '0;
          end
        end
        FR_PAYLOAD: begin
          // idx keeps the payload count into the pad field
          if (head[grant].last) begin
            if (idx < IW'(`MIN_PAYLOAD - 1)) begin
              state <= FR_PAD;
            end else begin
              state <= FR_FCS;
              idx   <= '0;
            end
          end
        end
        FR_PAD: begin
          if (idx == IW'(`MIN_PAYLOAD - 1)) begin
            state <= FR_FCS;
            idx   <= '0;
          end
        end
        default: begin
          // fcs, four bytes
          if (idx == IW'(3)) begin
            state <= FR_IDLE;
            idx   <= '0;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== net_tx_defines.svh ====
// shared build parameters of the transmit path
// MAX_PAYLOAD must stay below QUEUE_DEPTH so one whole frame fits a queue
// QUEUE_DEPTH must be a power of two, the queue pointers wrap freely
// bit 1 of LOCAL_MAC is overridden at the top level by mac_select
`ifndef NET_TX_DEFINES_SVH
`define NET_TX_DEFINES_SVH

// arp, icmp, udp
`define NUM_SOURCES     3

// bytes held per source queue
`define QUEUE_DEPTH     64

// payload limits in bytes, short payloads get zero padding
`define MAX_PAYLOAD     60
`define MIN_PAYLOAD     46

// largest credit count the sink may hand out
`define OUT_CREDIT_MAX  8

`define LOCAL_MAC       48'h02_4E_54_58_00_01
`define ETHERTYPE_ARP   16'h0806
`define ETHERTYPE_IPV4  16'h0800

`endif

// ==== net_tx_pkg.sv ====
// types shared by the transmit path
// src_sel_t values double as the generate index of each source queue
// numeric parameters live in the defines header
`default_nettype none

package net_tx_pkg;

  // ------------------------------
  // plain vectors
  // ------------------------------
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [31:0] crc_t;

  // source index, order is also the priority order
  typedef enum logic [1:0] {
    SRC_ARP  = 2'd0,
    SRC_ICMP = 2'd1,
    SRC_UDP  = 2'd2
  } src_sel_t;

  // framer fields in wire order
  typedef enum logic [2:0] {
    FR_IDLE,
    FR_PREAMBLE,
    FR_DEST,
    FR_SRC,
    FR_TYPE,
    FR_PAYLOAD,
    FR_PAD,
    FR_FCS
  } framer_state_t;

  // payload byte into and out of a source queue
  typedef struct packed {
    byte_t data;
    logic  last;
  } src_byte_t;

  // framed byte towards the sink, last marks the final fcs byte
  typedef struct packed {
    byte_t data;
    logic  last;
  } tx_byte_t;

endpackage

`default_nettype wire

// ==== net_tx_props.sv ====
// framer credit and grant rules, bound into every mac_framer
// fail_count lets the testbench see failed assertions at the end of the run
// sink credits are tracked here from the ports, apart from the framer counter
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module net_tx_props (
  input wire                                 tx_clock,
  input wire                                 rst_n,
  input wire                                 out_credit,
  input wire                                 out_valid,
  input wire [$clog2(`OUT_CREDIT_MAX+1)-1:0] credit_cnt,
  input wire [`NUM_SOURCES-1:0]              frame_ready,
  input wire [`NUM_SOURCES-1:0]              pop,
  input wire net_tx_pkg::src_sel_t           grant
);

  import net_tx_pkg::*;

  int fail_count = 0;

  // credits handed out by the sink and not yet spent
  logic [$clog2(`OUT_CREDIT_MAX+1):0] held;

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      held <= '0;
    end else begin
      held <= held + out_credit - out_valid;
    end
  end

  // a byte leaves only on a credit the sink gave
  a_send_credit: assert property (@(posedge tx_clock) disable iff (!rst_n)
    out_valid |-> (held != '0))
    else begin
      fail_count++;
      $error("out_valid while the framer holds no credit");
    end

  // counter bounded by the sink limit
  a_credit_max: assert property (@(posedge tx_clock) disable iff (!rst_n)
    credit_cnt <= `OUT_CREDIT_MAX)
    else begin
      fail_count++;
      $error("credit counter above OUT_CREDIT_MAX");
    end

  // pops only reach the granted queue, and that queue holds a whole frame
  a_pop_grant: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (pop != '0) |->
      (pop == ({{(`NUM_SOURCES-1){1'b0}}, 1'b1} << grant)) && frame_ready[grant])
    else begin
      fail_count++;
      $error("pop to a queue that holds no grant or no complete frame");
    end

endmodule

bind mac_framer net_tx_props i_props (
  .tx_clock    (tx_clock),
  .rst_n       (rst_n),
  .out_credit  (out_credit),
  .out_valid   (out_valid),
  .credit_cnt  (credit_cnt),
  .frame_ready (frame_ready),
  .pop         (pop),
  .grant       (grant)
);

`default_nettype wire

// ==== net_tx_top.sv ====
// transmit path top: one queue per source feeding the framer
// each source writes its queue directly and follows its own credits
// mac_select high clears bit 1 of the local address, low sets it
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module net_tx_top (
  input  wire                        tx_clock,
  input  wire                        rst_n,
  // sources, index order arp, icmp, udp
  input  wire [`NUM_SOURCES-1:0]     wr_valid,
  input  wire net_tx_pkg::src_byte_t wr_byte [`NUM_SOURCES],
  output logic [`NUM_SOURCES-1:0]    wr_credit,
  input  wire net_tx_pkg::mac_addr_t dest_mac [`NUM_SOURCES],
  input  wire                        mac_select,
  // sink
  input  wire                        out_credit,
  output logic                       out_valid,
  output net_tx_pkg::tx_byte_t       out_byte
);

  import net_tx_pkg::*;

  localparam mac_addr_t BASE_MAC = `LOCAL_MAC;

  logic [`NUM_SOURCES-1:0] frame_ready;
  logic [`NUM_SOURCES-1:0] pop;
  src_byte_t               head [`NUM_SOURCES];
  mac_addr_t               local_mac;

  // bit 1 follows the strap pin inverted
  assign local_mac = {BASE_MAC[47:2], ~mac_select, BASE_MAC[0]};

  // ------------------------------
  // source queues
  // ------------------------------
  for (genvar s = 0; s < `NUM_SOURCES; s++) begin : g_queue
    tx_frame_queue i_queue (
      .tx_clock    (tx_clock),
      .rst_n       (rst_n),
      .wr_valid    (wr_valid[s]),
      .wr_byte     (wr_byte[s]),
      .wr_credit   (wr_credit[s]),
      .pop         (pop[s]),
      .head        (head[s]),
      .frame_ready (frame_ready[s])
    );
  end

  // arbitration and framing
  mac_framer i_framer (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .frame_ready (frame_ready),
    .head        (head),
    .dest_mac    (dest_mac),
    .local_mac   (local_mac),
    .pop         (pop),
    .out_credit  (out_credit),
    .out_valid   (out_valid),
    .out_byte    (out_byte)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
net_tx_pkg.sv
tx_frame_queue.sv
eth_crc32.sv
mac_framer.sv
net_tx_top.sv
net_tx_props.sv
tb_checker.sv
tb_net_tx.sv

// ==== tb_checker.sv ====
// watches the framer output and compares each frame with its expected bytes
// source is told apart by ethertype (arp) or by dest mac (icmp, udp),
// so the icmp and udp dest addresses must differ while frames are in flight
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module tb_checker (
  input wire                        tx_clock,
  input wire                        rst_n,
  input wire                        out_valid,
  input wire net_tx_pkg::tx_byte_t  out_byte,
  input wire net_tx_pkg::mac_addr_t dest_mac [`NUM_SOURCES],
  input wire                        mac_select
);

  import net_tx_pkg::*;

  localparam crc_t CRC_POLY = 32'hEDB88320;

  byte_t exp_data [`NUM_SOURCES][$];
  int    exp_len [`NUM_SOURCES][$];
  byte_t rx [$];
  int    src_log [$];
  int    errors = 0;
  int    frames_done = 0;

  task automatic add_frame_byte(input int s, input byte_t b);
    exp_data[s].push_back(b);
  endtask

  task automatic close_frame(input int s, input int len);
    exp_len[s].push_back(len);
  endtask

  // ------------------------------
  // expected frame and compare
  // ------------------------------
  task automatic check_frame();
    byte_t     exp [$];
    mac_addr_t lmac;
    mac_addr_t rx_dest;
    crc_t      c;
    logic      fb;
    int        s;
    int        len;
    int        n;
    lmac = `LOCAL_MAC;
    // select high clears bit 1, low sets it
    lmac[1] = (mac_select == 1'b1) ? 1'b0 : 1'b1;
    s = -1;
    if (rx.size() < 26) begin
      errors++;
      $display("frame of %0d bytes at %0t is too short for a header", rx.size(), $time);
      rx.delete();
      return;
    end
    rx_dest = '0;
    for (int i = 8; i < 14; i++) begin
      rx_dest = {rx_dest[39:0], rx[i]};
    end
    if ({rx[20], rx[21]} == `ETHERTYPE_ARP) s = 0;
    else if (rx_dest == dest_mac[1]) s = 1;
    else if (rx_dest == dest_mac[2]) s = 2;
    if (s < 0 || exp_len[s].size() == 0) begin
      errors++;
      $display("frame at %0t matches no source with a pending frame", $time);
      rx.delete();
      return;
    end
    src_log.push_back(s);
    len = exp_len[s].pop_front();
    // preamble and sfd
    for (int i = 0; i < 7; i++) exp.push_back(8'h55);
    exp.push_back(8'hD5);
    for (int i = 0; i < 6; i++) exp.push_back(dest_mac[s][47-8*i -: 8]);
    for (int i = 0; i < 6; i++) exp.push_back(lmac[47-8*i -: 8]);
    if (s == 0) begin
      exp.push_back(8'h08);
      exp.push_back(8'h06);
    end else begin
      exp.push_back(8'h08);
      exp.push_back(8'h00);
    end
    for (int i = 0; i < len; i++) exp.push_back(exp_data[s].pop_front());
    for (int i = len; i < `MIN_PAYLOAD; i++) exp.push_back(8'h00);
    // bit-serial crc, lsb of each byte first
    c = '1;
    for (int i = 8; i < exp.size(); i++) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[0] ^ exp[i][b];
        c = c >> 1;
        if (fb) c = c ^ CRC_POLY;
      end
    end
    c = ~c;
    for (int i = 0; i < 4; i++) exp.push_back(c[8*i +: 8]);
    if (rx.size() != exp.size()) begin
      errors++;
      $display("error t=%0t frame length of source %0d: got %0d expected %0d",
               $time, s, rx.size(), exp.size());
    end
    n = (rx.size() < exp.size()) ? rx.size() : exp.size();
    for (int i = 0; i < n; i++) begin
      if (rx[i] !== exp[i]) begin
        errors++;
        $display("error t=%0t out_byte.data byte %0d: got %h expected %h",
                 $time, i, rx[i], exp[i]);
      end
    end
    rx.delete();
  endtask

  // sampled mid-cycle, where out_valid and out_byte have settled
  always @(negedge tx_clock) begin
    if (rst_n && out_valid) begin
      rx.push_back(out_byte.data);
      if (out_byte.last) begin
        check_frame();
        frames_done++;
      end else if (rx.size() > 200) begin
        errors++;
        $display("frame at %0t runs past 200 bytes without last", $time);
        rx.delete();
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_net_tx.sv ====
// transmit path testbench, lcg stimulus with a fixed seed
// writer and sink credits are modelled here, frames checked in tb_checker
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module tb_net_tx;

  import net_tx_pkg::*;

  logic                    tx_clock = 1'b0;
  logic                    rst_n;
  logic [`NUM_SOURCES-1:0] wr_valid;
  src_byte_t               wr_byte [`NUM_SOURCES];
  logic [`NUM_SOURCES-1:0] wr_credit;
  mac_addr_t               dest_mac [`NUM_SOURCES];
  logic                    mac_select;
  logic                    out_credit;
  logic                    out_valid;
  tx_byte_t                out_byte;

  int unsigned rng_state = 32'h18018cc9;
  src_byte_t   pend [`NUM_SOURCES][$];
  int          wr_cnt [`NUM_SOURCES];
  bit          credit_fault = 1'b0;
  int          sink_cnt = 0;
  logic        sink_given = 1'b0;
  logic        sink_seen = 1'b0;
  bit          sink_enable = 1'b1;
  int unsigned credit_gap_max = 0;
  int unsigned write_gap_max = 0;
  int          frames_sent = 0;
  int          cycles = 0;
  int          cycle_limit = 2000;
  int          tests_failed = 0;
  int          err_base;
  int          log_base;
  bit          ok;

  net_tx_top i_dut (
    .tx_clock (tx_clock), .rst_n (rst_n),
    .wr_valid (wr_valid), .wr_byte (wr_byte), .wr_credit (wr_credit),
    .dest_mac (dest_mac), .mac_select (mac_select),
    .out_credit (out_credit), .out_valid (out_valid), .out_byte (out_byte)
  );

  tb_checker i_chk (
    .tx_clock (tx_clock), .rst_n (rst_n), .out_valid (out_valid),
    .out_byte (out_byte), .dest_mac (dest_mac), .mac_select (mac_select)
  );

  always #2 tx_clock = ~tx_clock;

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = lcg_next();
    return (r >> 8) % n;
  endfunction

  // ------------------------------
  // watchdog
  // ------------------------------
  always @(posedge tx_clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, frames still missing at the output", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // writer and sink, driven 1 ns after the edge
  always @(posedge tx_clock) begin
    #1;
    if (!rst_n) begin
      wr_valid = '0;
      out_credit = 1'b0;
      sink_cnt = 0;
      sink_given = 1'b0;
      sink_seen = 1'b0;
      for (int s = 0; s < `NUM_SOURCES; s++) wr_cnt[s] = `QUEUE_DEPTH;
    end else begin
      for (int s = 0; s < `NUM_SOURCES; s++) begin
        if (wr_credit[s]) wr_cnt[s]++;
        if (wr_cnt[s] > `QUEUE_DEPTH) begin
          credit_fault = 1'b1;
          $display("source %0d holds %0d write credits at %0t, more than the queue depth",
                   s, wr_cnt[s], $time);
        end
        wr_valid[s] = 1'b0;
        if (pend[s].size() > 0 && wr_cnt[s] > 0 && rand_below(write_gap_max + 1) == 0) begin
          wr_byte[s] = pend[s].pop_front();
          wr_valid[s] = 1'b1;
          wr_cnt[s]--;
        end
      end
      // mirror of the framer credit counter
      sink_cnt = sink_cnt + int'(sink_given) - int'(sink_seen);
      sink_seen = out_valid;
      sink_given = sink_enable && (sink_cnt < `OUT_CREDIT_MAX) &&
                   (rand_below(credit_gap_max + 1) == 0);
      out_credit = sink_given;
    end
  end

  task automatic queue_frame(input int s, input int len);
    src_byte_t b;
    for (int i = 0; i < len; i++) begin
      b.data = byte_t'(rand_below(256));
      b.last = (i == len - 1);
      pend[s].push_back(b);
      i_chk.add_frame_byte(s, b.data);
    end
    i_chk.close_frame(s, len);
    frames_sent++;
    cycle_limit += 4 * (((len < `MIN_PAYLOAD) ? `MIN_PAYLOAD : len) + 26);
  endtask

  // icmp and udp addresses differ in bit 0
  task automatic pick_dests();
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      dest_mac[s] = {16'(lcg_next()), 32'(lcg_next())};
    end
    dest_mac[1][0] = 1'b0;
    dest_mac[2][0] = 1'b1;
  endtask

  task automatic wait_drained();
    while (pend[0].size() + pend[1].size() + pend[2].size() > 0 ||
           i_chk.frames_done < frames_sent) begin
      @(posedge tx_clock);
    end
  endtask

  task automatic apply_reset();
    @(posedge tx_clock);
    #1;
    rst_n = 1'b0;
    repeat (4) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;
    cycle_limit += 10;
  endtask

  task automatic report_test(input string name, input bit passed);
    if (passed) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail", name);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    rst_n = 1'b0;
    wr_valid = '0;
    mac_select = 1'b0;
    out_credit = 1'b0;
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      wr_byte[s] = '0;
      dest_mac[s] = '0;
    end
    repeat (4) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;
    pick_dests();

    err_base = i_chk.errors;
    for (int s = 0; s < `NUM_SOURCES; s++) queue_frame(s, 46 + int'(rand_below(15)));
    wait_drained();
    report_test("frame_format", i_chk.errors == err_base);

    err_base = i_chk.errors;
    queue_frame(0, 1);
    queue_frame(1, 45);
    queue_frame(2, `MAX_PAYLOAD);
    wait_drained();
    report_test("padding", i_chk.errors == err_base);

    // no credits held, frames loaded lowest priority first
    err_base = i_chk.errors;
    sink_enable = 1'b0;
    apply_reset();
    queue_frame(2, 1 + int'(rand_below(`MAX_PAYLOAD)));
    queue_frame(1, 1 + int'(rand_below(`MAX_PAYLOAD)));
    queue_frame(0, 1 + int'(rand_below(`MAX_PAYLOAD)));
    while (pend[0].size() + pend[1].size() + pend[2].size() > 0) @(posedge tx_clock);
    repeat (4) @(posedge tx_clock);
    cycle_limit += 200;
    log_base = i_chk.src_log.size();
    sink_enable = 1'b1;
    wait_drained();
    ok = (i_chk.errors == err_base) && (i_chk.src_log.size() == log_base + 3);
    if (ok) ok = (i_chk.src_log[log_base] == 0) && (i_chk.src_log[log_base + 1] == 1) &&
                 (i_chk.src_log[log_base + 2] == 2);
    report_test("priority", ok);

    err_base = i_chk.errors;
    write_gap_max = 2;
    credit_gap_max = 2;
    for (int f = 0; f < 200; f++) begin
      queue_frame(int'(rand_below(3)), 1 + int'(rand_below(`MAX_PAYLOAD)));
    end
    wait_drained();
    report_test("back_pressure", i_chk.errors == err_base);

    repeat (4) @(posedge tx_clock);
    ok = !credit_fault;
    for (int s = 0; s < `NUM_SOURCES; s++) begin
      if (wr_cnt[s] != `QUEUE_DEPTH) begin
        ok = 1'b0;
        $display("error t=%0t wr_credit total of source %0d: got %0d expected %0d",
                 $time, s, wr_cnt[s], `QUEUE_DEPTH);
      end
    end
    report_test("input_credits", ok);

    // mac_select low was covered above
    err_base = i_chk.errors;
    write_gap_max = 0;
    credit_gap_max = 0;
    #1;
    mac_select = 1'b1;
    for (int s = 0; s < `NUM_SOURCES; s++) queue_frame(s, 1 + int'(rand_below(`MAX_PAYLOAD)));
    wait_drained();
    report_test("local_mac", i_chk.errors == err_base);

    $display("tests 6, failed %0d, byte errors %0d, frames %0d, assertion failures %0d",
             tests_failed, i_chk.errors, i_chk.frames_done,
             i_dut.i_framer.i_props.fail_count);
    if (tests_failed == 0 && i_chk.errors == 0 && i_dut.i_framer.i_props.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tx_frame_queue.sv ====
// per-source payload FIFO with a count of complete frames
// writer must hold to its credits, a write into a full queue is not caught
// popping an empty queue is not guarded, the framer pops only ready frames
// head is read combinationally from the oldest entry
`timescale 1ns/1ps
`default_nettype none
`include "net_tx_defines.svh"

module tx_frame_queue (
  input  wire                    tx_clock,
  input  wire                    rst_n,
  // writer side
  input  wire                    wr_valid,
  input  wire net_tx_pkg::src_byte_t wr_byte,
  output logic                   wr_credit,
  // framer side
  input  wire                    pop,
  output net_tx_pkg::src_byte_t  head,
  output logic                   frame_ready
);

  import net_tx_pkg::*;

  localparam int AW = $clog2(`QUEUE_DEPTH);
  // up to one frame per entry
  localparam int FW = $clog2(`QUEUE_DEPTH + 1);

  src_byte_t     mem [`QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [FW-1:0] frame_cnt;
  logic          wr_last;
  logic          pop_last;

  // frame boundaries on both ends
  assign wr_last  = wr_valid && wr_byte.last;
  assign pop_last = pop && head.last;

  // ------------------------------
  // storage
  // ------------------------------
  always_ff @(posedge tx_clock) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_byte;
    end
  end

  assign head = mem[rd_ptr];

  // pointers wrap at the power-of-two depth
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------
  // frame count and credits
  // ------------------------------
  // rises the cycle after a last byte lands
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else begin
      case ({wr_last, pop_last})
        2'b10:   frame_cnt <= frame_cnt + 1'b1;
        2'b01:   frame_cnt <= frame_cnt - 1'b1;
        default: frame_cnt <= frame_cnt;
      endcase
    end
  end

  assign frame_ready = (frame_cnt != '0);

  // one credit back per freed entry
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_credit <= 1'b0;
    end else begin
      wr_credit <= pop;
    end
  end

endmodule

`default_nettype wire
